//--- design/cachePkg.sv
package cachePkg;
	localparam int addressWidth = 16;
	localparam int dataWidth = 32;
	localparam int indexWidth = 3;

	typedef logic [addressWidth-1:0] addressT;
	typedef logic [dataWidth-1:0] dataT;
	typedef logic [indexWidth-1:0] indexT;
	typedef logic [addressWidth-indexWidth-1:0] tagT;

	typedef enum logic [2:0] {
		busNone,
		busRead,
		busReadExclusive,
		busUpgrade,
		busWriteBack
	} busCommandT;

	typedef enum logic [1:0] {
		lineInvalid,
		lineShared,
		lineModified
	} lineStateT;

	// Device side memory port
	typedef struct packed {
		addressT address;
		dataT writeData;
		logic readEnabled;
		logic writeEnabled;
	} deviceRequestT;

	typedef struct packed {
		dataT readData;
		logic functionComplete;
	} deviceResponseT;

	typedef struct packed {
		busCommandT command;
		addressT address;
	} busRequestT;

	typedef struct packed {
		busCommandT command;
		addressT address;
		logic valid; // Never set toward the requesting cache
	} snoopT;
endpackage

//--- design/cacheController.sv
`timescale 1ns/1ps

module cacheController (
	input logic clock,
	input logic rstN,
	input cachePkg::deviceRequestT request,
	output cachePkg::deviceResponseT response,
	output cachePkg::busRequestT busRequest,
	input logic grantDone,
	input cachePkg::dataT fillData,
	output cachePkg::dataT writeBackData,
	input cachePkg::snoopT snoop,
	output logic snoopHit,
	output logic snoopDirty,
	output cachePkg::dataT snoopData
);
	localparam int lineCount = 2 ** cachePkg::indexWidth;

	typedef enum logic [2:0] {
		cacheIdle,
		cacheWriteBack,
		cacheFetch,
		cacheUpgrade,
		cacheRespond
	} cacheStateT;

	cacheStateT state;

	cachePkg::tagT tagArray [lineCount];
	cachePkg::dataT dataArray [lineCount];
	cachePkg::lineStateT stateArray [lineCount];

	cachePkg::indexT reqIndex;
	cachePkg::tagT reqTag;
	cachePkg::indexT snoopIndex;
	cachePkg::tagT snoopTag;
	cachePkg::lineStateT lineState;
	logic tagMatch;
	logic readHit, writeHit, writeShared, victimDirty;
	logic snoopConflict, accept;
	logic writeBackDone, fillLine, upgradeDone;

	assign reqIndex = request.address[cachePkg::indexWidth-1:0];
	assign reqTag = request.address[cachePkg::addressWidth-1:cachePkg::indexWidth];
	assign lineState = stateArray[reqIndex];
	assign tagMatch = tagArray[reqIndex] == reqTag;

	assign readHit = request.readEnabled && lineState != cachePkg::lineInvalid && tagMatch;
	assign writeHit = request.writeEnabled && lineState == cachePkg::lineModified && tagMatch;
	assign writeShared = request.writeEnabled && lineState == cachePkg::lineShared && tagMatch;
	assign victimDirty = lineState == cachePkg::lineModified && !tagMatch;

	// A snoop to the same line takes priority over a new device access
	assign snoopConflict = snoop.valid && snoopIndex == reqIndex;
	assign accept = state == cacheIdle && (request.readEnabled || request.writeEnabled) &&
		!response.functionComplete && !snoopConflict;

	assign writeBackDone = state == cacheWriteBack && grantDone;
	assign fillLine = state == cacheFetch && grantDone;
	assign upgradeDone = state == cacheUpgrade && grantDone;

	always_comb begin
		busRequest.command = cachePkg::busNone;
		busRequest.address = request.address;
		case (state)
			cacheWriteBack: begin
				busRequest.command = cachePkg::busWriteBack;
				busRequest.address = {tagArray[reqIndex], reqIndex}; // Victim address
			end
			cacheFetch: busRequest.command = request.writeEnabled ?
				cachePkg::busReadExclusive : cachePkg::busRead;
			cacheUpgrade: busRequest.command = cachePkg::busUpgrade;
			default: ;
		endcase
	end
	assign writeBackData = dataArray[reqIndex];

	// Snoop side
	assign snoopIndex = snoop.address[cachePkg::indexWidth-1:0];
	assign snoopTag = snoop.address[cachePkg::addressWidth-1:cachePkg::indexWidth];
	assign snoopHit = snoop.valid && stateArray[snoopIndex] != cachePkg::lineInvalid &&
		tagArray[snoopIndex] == snoopTag;
	assign snoopDirty = snoopHit && stateArray[snoopIndex] == cachePkg::lineModified;
	assign snoopData = dataArray[snoopIndex];

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= cacheIdle;
			response <= '0;
		end else begin
			response.functionComplete <= 1'b0;
			case (state)
				cacheIdle: if (accept) begin
					if (readHit || writeHit) begin
						response.functionComplete <= 1'b1;
						response.readData <= readHit ? dataArray[reqIndex] : request.writeData;
					end else if (writeShared) begin
						state <= cacheUpgrade;
					end else if (victimDirty) begin
						state <= cacheWriteBack;
					end else begin
						state <= cacheFetch;
					end
				end
				// A peer may take the line while this cache waits for the bus
				cacheWriteBack: begin
					if (writeBackDone || !victimDirty)
						state <= cacheFetch;
				end
				cacheUpgrade: begin
					if (upgradeDone)
						state <= cacheRespond;
					else if (!(lineState == cachePkg::lineShared && tagMatch))
						state <= cacheFetch;
				end
				cacheFetch: if (fillLine) state <= cacheRespond;
				cacheRespond: begin
					response.functionComplete <= 1'b1;
					response.readData <= dataArray[reqIndex];
					state <= cacheIdle;
				end
				default: state <= cacheIdle;
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < lineCount; i++)
				stateArray[i] <= cachePkg::lineInvalid;
		end else begin
			if (writeBackDone)
				stateArray[reqIndex] <= cachePkg::lineInvalid;
			if (fillLine)
				stateArray[reqIndex] <= request.writeEnabled ?
					cachePkg::lineModified : cachePkg::lineShared;
			if (upgradeDone)
				stateArray[reqIndex] <= cachePkg::lineModified;
			if (snoopHit) begin
				case (snoop.command)
					cachePkg::busRead:
						if (snoopDirty) stateArray[snoopIndex] <= cachePkg::lineShared;
					cachePkg::busReadExclusive, cachePkg::busUpgrade:
						stateArray[snoopIndex] <= cachePkg::lineInvalid;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept && writeHit)
			dataArray[reqIndex] <= request.writeData;
		if (fillLine) begin
			tagArray[reqIndex] <= reqTag;
			dataArray[reqIndex] <= request.writeEnabled ? request.writeData : fillData;
		end
		if (upgradeDone)
			dataArray[reqIndex] <= request.writeData;
	end
endmodule

//--- design/coherenceBus.sv
`timescale 1ns/1ps

module coherenceBus #(
	parameter int numberOfDevices = 2
) (
	input logic clock,
	input logic rstN,
	input cachePkg::busRequestT busRequest [numberOfDevices],
	output logic [numberOfDevices-1:0] grantDone,
	output cachePkg::dataT fillData,
	input cachePkg::dataT writeBackData [numberOfDevices],
	output cachePkg::snoopT snoop [numberOfDevices],
	input logic [numberOfDevices-1:0] snoopHit,
	input logic [numberOfDevices-1:0] snoopDirty,
	input cachePkg::dataT snoopData [numberOfDevices],
	output logic ramRequest,
	output logic ramWrite,
	output cachePkg::addressT ramAddress,
	output cachePkg::dataT ramWriteData,
	input logic ramReady,
	input cachePkg::dataT ramReadData
);
	localparam int ownerWidth = numberOfDevices > 1 ? $clog2(numberOfDevices) : 1;

	typedef enum logic [1:0] {seqIdle, seqSnoop, seqRamAccess, seqFinish} sequencerT;

	sequencerT state;
	logic [ownerWidth-1:0] owner, winner;
	logic anyRequest, anyDirty;
	cachePkg::busCommandT command;
	cachePkg::dataT dirtyData;

	// Round robin search starts just after the last owner
	always_comb begin
		int candidate;
		winner = owner;
		anyRequest = 1'b0;
		for (int k = 1; k <= numberOfDevices; k++) begin
			candidate = (int'(owner) + k) % numberOfDevices;
			if (!anyRequest && busRequest[candidate].command != cachePkg::busNone) begin
				anyRequest = 1'b1;
				winner = ownerWidth'(candidate);
			end
		end
	end

	always_comb begin
		anyDirty = 1'b0;
		dirtyData = '0;
		for (int i = 0; i < numberOfDevices; i++) begin
			if (i != int'(owner) && snoopHit[i] && snoopDirty[i]) begin
				anyDirty = 1'b1;
				dirtyData = snoopData[i];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < numberOfDevices; i++) begin
			snoop[i].command = command;
			snoop[i].address = ramAddress;
			snoop[i].valid = state == seqSnoop && i != int'(owner);
			grantDone[i] = state == seqFinish && i == int'(owner);
		end
	end

	assign ramRequest = state == seqRamAccess;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= seqIdle;
			owner <= '0;
			command <= cachePkg::busNone;
			ramAddress <= '0;
			ramWrite <= 1'b0;
			ramWriteData <= '0;
			fillData <= '0;
		end else begin
			case (state)
				seqIdle: if (anyRequest) begin
					owner <= winner;
					command <= busRequest[winner].command;
					ramAddress <= busRequest[winner].address;
					if (busRequest[winner].command == cachePkg::busWriteBack) begin
						ramWrite <= 1'b1; // Victim goes straight to RAM
						ramWriteData <= writeBackData[winner];
						state <= seqRamAccess;
					end else begin
						state <= seqSnoop;
					end
				end
				seqSnoop: begin
					if (anyDirty) begin
						ramWrite <= 1'b1;
						ramWriteData <= dirtyData;
						fillData <= dirtyData;
						state <= seqRamAccess;
					end else if (command == cachePkg::busUpgrade) begin
						state <= seqFinish;
					end else begin
						ramWrite <= 1'b0;
						state <= seqRamAccess;
					end
				end
				seqRamAccess: if (ramReady) begin
					if (!ramWrite)
						fillData <= ramReadData;
					state <= seqFinish;
				end
				default: state <= seqIdle;
			endcase
		end
	end
endmodule

//--- design/ram.sv
`timescale 1ns/1ps

module ram #(
	parameter int ramDelay = 3,
	parameter int ramWords = 256
) (
	input logic clock,
	input logic rstN,
	input logic ramRequest,
	input logic ramWrite,
	input cachePkg::addressT ramAddress,
	input cachePkg::dataT ramWriteData,
	output logic ramReady,
	output cachePkg::dataT ramReadData
);
	localparam int wordBits = $clog2(ramWords);
	localparam int countWidth = $clog2(ramDelay + 1);

	cachePkg::dataT memory [ramWords];
	logic busy;
	logic [countWidth-1:0] count;
	logic [wordBits-1:0] wordIndex;
	logic start, fire;

	assign wordIndex = ramAddress[wordBits-1:0];
	assign start = ramRequest && !busy && !ramReady; // Request is still high in the ready cycle
	assign fire = busy ? count == countWidth'(1) : start && ramDelay == 1;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			count <= '0;
			ramReady <= 1'b0;
			ramReadData <= '0;
			for (int i = 0; i < ramWords; i++)
				memory[i] <= '0;
		end else begin
			ramReady <= fire;
			if (fire) begin
				busy <= 1'b0;
				if (ramWrite)
					memory[wordIndex] <= ramWriteData;
				else
					ramReadData <= memory[wordIndex];
			end else if (start) begin
				busy <= 1'b1;
				count <= countWidth'(ramDelay - 1);
			end else if (busy) begin
				count <= count - 1'b1;
			end
		end
	end
endmodule

//--- design/memorySystem.sv
`timescale 1ns/1ps

module memorySystem #(
	parameter int numberOfDevices = 2,
	parameter int ramDelay = 3,
	parameter int ramWords = (2 ** cachePkg::addressWidth > 256) ? 256 : 2 ** cachePkg::addressWidth
) (
	input logic clock,
	input logic rstN,
	input cachePkg::deviceRequestT request [numberOfDevices],
	output cachePkg::deviceResponseT response [numberOfDevices]
);
	cachePkg::busRequestT busRequest [numberOfDevices];
	cachePkg::dataT writeBackData [numberOfDevices];
	cachePkg::snoopT snoop [numberOfDevices];
	cachePkg::dataT snoopData [numberOfDevices];
	logic [numberOfDevices-1:0] grantDone;
	logic [numberOfDevices-1:0] snoopHit;
	logic [numberOfDevices-1:0] snoopDirty;
	cachePkg::dataT fillData;

	logic ramRequest, ramWrite, ramReady;
	cachePkg::addressT ramAddress;
	cachePkg::dataT ramWriteData, ramReadData;

	// One private cache per device
	for (genvar i = 0; i < numberOfDevices; i++) begin : cacheGen
		cacheController cache (
			.clock(clock),
			.rstN(rstN),
			.request(request[i]),
			.response(response[i]),
			.busRequest(busRequest[i]),
			.grantDone(grantDone[i]),
			.fillData(fillData),
			.writeBackData(writeBackData[i]),
			.snoop(snoop[i]),
			.snoopHit(snoopHit[i]),
			.snoopDirty(snoopDirty[i]),
			.snoopData(snoopData[i])
		);
	end

	coherenceBus #(
		.numberOfDevices(numberOfDevices)
	) bus (
		.clock(clock),
		.rstN(rstN),
		.busRequest(busRequest),
		.grantDone(grantDone),
		.fillData(fillData),
		.writeBackData(writeBackData),
		.snoop(snoop),
		.snoopHit(snoopHit),
		.snoopDirty(snoopDirty),
		.snoopData(snoopData),
		.ramRequest(ramRequest),
		.ramWrite(ramWrite),
		.ramAddress(ramAddress),
		.ramWriteData(ramWriteData),
		.ramReady(ramReady),
		.ramReadData(ramReadData)
	);

	ram #(
		.ramDelay(ramDelay),
		.ramWords(ramWords)
	) mainMemory (
		.clock(clock),
		.rstN(rstN),
		.ramRequest(ramRequest),
		.ramWrite(ramWrite),
		.ramAddress(ramAddress),
		.ramWriteData(ramWriteData),
		.ramReady(ramReady),
		.ramReadData(ramReadData)
	);
endmodule

//--- verification/memorySystem_assert.sv
`timescale 1ns/1ps

module memorySystemAssert #(
	parameter int numberOfDevices = 2
) (
	input logic clock,
	input logic rstN,
	input cachePkg::deviceRequestT request [numberOfDevices],
	input cachePkg::deviceResponseT response [numberOfDevices],
	input logic [numberOfDevices-1:0] grantDone
);
	int failureCount = 0;

	for (genvar i = 0; i < numberOfDevices; i++) begin : deviceChecks
		// Completion is a single cycle pulse
		singlePulse: assert property (@(posedge clock) disable iff (!rstN)
			response[i].functionComplete |=> !response[i].functionComplete)
		else begin
			$error("functionComplete of device %0d stayed high for two cycles", i);
			failureCount++;
		end

		exclusiveEnable: assert property (@(posedge clock) disable iff (!rstN)
			!(request[i].readEnabled && request[i].writeEnabled))
		else begin
			$error("Device %0d raised readEnabled and writeEnabled together", i);
			failureCount++;
		end
	end

	oneGrant: assert property (@(posedge clock) disable iff (!rstN) $onehot0(grantDone))
	else begin
		$error("More than one grantDone high: %b", grantDone);
		failureCount++;
	end
endmodule

bind memorySystem memorySystemAssert #(
	.numberOfDevices(numberOfDevices)
) assertions (
	.clock(clock),
	.rstN(rstN),
	.request(request),
	.response(response),
	.grantDone(grantDone)
);

//--- verification/memorySystemTb.sv
`timescale 1ns/1ps

module memorySystemTb;
	localparam int devices = 2;
	localparam int ramDelay = 3;
	localparam int clockPeriod = 40;

	logic clock;
	logic rstN;
	cachePkg::deviceRequestT request [devices];
	cachePkg::deviceResponseT response [devices];

	// Trace columns with one entry per operation
	int testQ[$];
	int deviceQ[$];
	int opQ[$];
	cachePkg::addressT addressQ[$];
	cachePkg::dataT writeDataQ[$];
	cachePkg::dataT expectedQ[$];
	int concurrentQ[$];

	int traceLength = 0;
	int mismatches = 0;
	int testErrors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int pendingOp [devices]; // Trace entry in flight per device or -1

	memorySystem #(
		.numberOfDevices(devices),
		.ramDelay(ramDelay)
	) u_memorySystem (
		.clock(clock),
		.rstN(rstN),
		.request(request),
		.response(response)
	);

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	task automatic loadTrace();
		int fd;
		int fields;
		string line;
		int t, d, o, c;
		logic [31:0] a, w, e;
		fd = $fopen("verification/memoryTrace.txt", "r");
		if (fd == 0) begin
			$display("Trace file verification/memoryTrace.txt could not be opened");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line[0] != "#") begin
				fields = $sscanf(line, "%d %d %d %h %h %h %d", t, d, o, a, w, e, c);
				if (fields == 7) begin
					testQ.push_back(t);
					deviceQ.push_back(d);
					opQ.push_back(o);
					addressQ.push_back(a[15:0]);
					writeDataQ.push_back(w);
					expectedQ.push_back(e);
					concurrentQ.push_back(c);
				end
			end
		end
		$fclose(fd);
	endtask

	// Holds one request until functionComplete and checks the read data
	task automatic runOperation(input int i);
		int dev;
		cachePkg::deviceRequestT req;
		cachePkg::dataT got;
		dev = deviceQ[i];
		req = '0;
		req.address = addressQ[i];
		req.writeData = writeDataQ[i];
		req.readEnabled = opQ[i] == 0;
		req.writeEnabled = opQ[i] == 1;
		pendingOp[dev] = i;
		request[dev] = req;
		do begin
			@(posedge clock);
			#2;
		end while (!response[dev].functionComplete);
		got = response[dev].readData;
		request[dev] = '0;
		pendingOp[dev] = -1;
		if (opQ[i] == 0 && got !== expectedQ[i]) begin
			$display("MISMATCH readData test %0d device %0d address %h: expected %h, got %h",
				testQ[i], dev, addressQ[i], expectedQ[i], got);
			mismatches++;
			testErrors++;
		end
	endtask

	task automatic reportTest(input int number);
		testsRun++;
		if (testErrors == 0) begin
			$display("Test %0d finished: ok", number);
		end else begin
			testsFailed++;
			$display("Test %0d finished: %0d mismatches", number, testErrors);
		end
		testErrors = 0;
	endtask

	initial begin
		int i;
		rstN = 1'b0;
		for (int k = 0; k < devices; k++) begin
			request[k] = '0;
			pendingOp[k] = -1;
		end
		loadTrace();
		repeat (3) @(posedge clock);
		#2 rstN = 1'b1;
		if (testQ.size() == 0) begin
			$display("No operations were read from the trace");
			mismatches++;
		end
		traceLength = testQ.size();
		i = 0;
		while (i < traceLength) begin
			if (concurrentQ[i] != 0 && i + 1 < traceLength) begin
				fork
					runOperation(i);
					runOperation(i + 1);
				join
				i = i + 2;
			end else begin
				runOperation(i);
				i = i + 1;
			end
			if (i >= traceLength || testQ[i] != testQ[i - 1])
				reportTest(testQ[i - 1]);
		end
		mismatches += u_memorySystem.assertions.failureCount;
		$display("Summary: %0d tests run, %0d failed, %0d errors in total",
			testsRun, testsFailed, mismatches);
		if (mismatches == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Watchdog sized from the trace length
	initial begin
		longint limit;
		wait (traceLength > 0);
		limit = longint'(traceLength) * (4 * ramDelay + 12) * clockPeriod;
		#(limit);
		for (int k = 0; k < devices; k++)
			if (pendingOp[k] >= 0)
				$display("Timeout: request of trace operation %0d on device %0d never completed",
					pendingOp[k], k);
		$display("Watchdog expired after %0d ns", limit);
		$display("Some tests failed");
		$finish;
	end
endmodule

//--- verilog.f
design/cachePkg.sv
design/cacheController.sv
design/coherenceBus.sv
design/ram.sv
design/memorySystem.sv
verification/memorySystem_assert.sv
verification/memorySystemTb.sv

//--- verification/memoryTrace.txt
# test device op(0 read, 1 write) address(hex) writeData(hex) expected(hex) concurrent
# expected is checked on reads only; concurrent 1 issues the line together with the next one
1 0 0 0010 00000000 00000000 0
1 1 0 0023 00000000 00000000 0
1 0 0 00f7 00000000 00000000 0
2 0 1 0041 deadbeef 00000000 0
2 0 0 0041 00000000 deadbeef 0
2 1 1 0052 12345678 00000000 0
2 1 0 0052 00000000 12345678 0
2 1 1 0052 0badcafe 00000000 0
2 1 0 0052 00000000 0badcafe 0
3 0 1 0064 a5a5a5a5 00000000 0
3 1 0 0064 00000000 a5a5a5a5 0
3 0 0 0064 00000000 a5a5a5a5 0
4 0 0 0035 00000000 00000000 0
4 1 0 0035 00000000 00000000 0
4 1 1 0035 11112222 00000000 0
4 0 0 0035 00000000 11112222 0
4 1 0 0035 00000000 11112222 0
5 0 1 0016 cafef00d 00000000 0
5 0 1 0026 0f0f0f0f 00000000 0
5 0 0 0016 00000000 cafef00d 0
5 1 0 0026 00000000 0f0f0f0f 0
6 0 1 0077 77777777 00000000 1
6 1 1 0088 88888888 00000000 0
6 0 0 0088 00000000 88888888 1
6 1 0 0077 00000000 77777777 0
6 0 0 00a3 00000000 00000000 1
6 1 0 00c4 00000000 00000000 0
